// ==== files.f ====
hw/acq_pkg.sv
hw/sample_pkg.sv
hw/sample_pacer.sv
hw/edge_detector.sv
hw/ext_trig_qualifier.sv
hw/acq_fsm.sv
hw/acq_trigger_top.sv
test/tb_clk_gen.sv
test/tb_acq_trigger.sv

// ==== hw/acq_fsm.sv ====
// lengths are sampled live, so keep pre/post_length static during an acquisition
`default_nettype none

module acq_fsm #(
   parameter int ADDR_W = 10
) (
   input  logic                        clklvds,
   input  logic                        rst_n,
   input  logic                        trigger_live,   // host allows a new acquisition
   input  logic [7:0]                  trigger_type,
   input  logic [acq_pkg::LEN_W-1:0]   pre_length,     // strobes before the trigger
   input  logic [acq_pkg::LEN_W-1:0]   post_length,    // strobes after the trigger
   input  logic                        readout_done,   // level, only looked at in done
   input  logic                        strobe,
   input  logic [ADDR_W-1:0]           ram_wr_address,
   input  logic                        arm_hit,
   input  logic                        fire_hit,
   input  logic                        ext_fire,
   output logic                        recording,
   output logic                        rising,
   output logic                        ext_enable,
   output logic                        trig_out,
   output acq_pkg::acq_state_t         acq_state,
   output logic [ADDR_W-1:0]           ram_address_triggered,
   output logic [acq_pkg::TIME_W-1:0]  event_count,
   output logic [acq_pkg::TIME_W-1:0]  event_time
);

   logic [7:0]                 active_type;  // type latched when leaving ready
   logic [acq_pkg::LEN_W-1:0]  len_cnt;      // shared pre and post strobe count
   logic [acq_pkg::LEN_W-1:0]  len_limit;
   logic                       len_last;     // this clock ends the window
   logic                       type_changed;
   logic                       fire;         // moving to post this clock
   logic [acq_pkg::TIME_W-1:0] time_cnt;     // free running event clock

   assign recording    = (acq_state != acq_pkg::ST_READY) && (acq_state != acq_pkg::ST_DONE);
   assign trig_out     = acq_state == acq_pkg::ST_POST;
   assign ext_enable   = acq_state == acq_pkg::ST_EXT;
   assign rising       = active_type == acq_pkg::TRIG_RISING;
   assign type_changed = trigger_type != active_type; // host switched type mid run
   assign len_limit    = (acq_state == acq_pkg::ST_POST) ? post_length : pre_length;
   assign len_last     = (len_limit == '0) ||
                         (strobe && (len_cnt == len_limit - 1'b1)); // zero length leaves at once

   always_comb begin
      case (acq_state)
         acq_pkg::ST_EDGE_FIRE: fire = fire_hit && !type_changed;
         acq_pkg::ST_AUTO:      fire = !type_changed;
         acq_pkg::ST_EXT:       fire = ext_fire && !type_changed;
         default:               fire = 1'b0;
      endcase
   end

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         acq_state   <= acq_pkg::ST_READY;
         active_type <= acq_pkg::TRIG_NONE;
         len_cnt     <= '0;
         event_count <= '0;
         time_cnt    <= '0;
      end else begin
         time_cnt <= time_cnt + 1'b1;
         case (acq_state)
            acq_pkg::ST_READY: begin
               len_cnt <= '0;
               if (trigger_live && (trigger_type != acq_pkg::TRIG_NONE)) begin
                  active_type <= trigger_type;
                  acq_state   <= acq_pkg::ST_PRE;
               end
            end
            acq_pkg::ST_PRE: begin
               if (type_changed) begin
                  acq_state <= acq_pkg::ST_READY;
               end else if (len_last) begin
                  len_cnt <= '0; // reused for the post window
                  case (active_type)
                     acq_pkg::TRIG_RISING,
                     acq_pkg::TRIG_FALLING: acq_state <= acq_pkg::ST_EDGE_ARM;
                     acq_pkg::TRIG_AUTO:    acq_state <= acq_pkg::ST_AUTO;
                     acq_pkg::TRIG_EXT:     acq_state <= acq_pkg::ST_EXT;
                     default:               acq_state <= acq_pkg::ST_READY; // unsupported type
                  endcase
               end else if (strobe) begin
                  len_cnt <= len_cnt + 1'b1;
               end
            end
            acq_pkg::ST_EDGE_ARM: begin
               if (type_changed) begin
                  acq_state <= acq_pkg::ST_READY;
               end else if (arm_hit) begin
                  acq_state <= acq_pkg::ST_EDGE_FIRE;
               end
            end
            acq_pkg::ST_EDGE_FIRE,
            acq_pkg::ST_AUTO,
            acq_pkg::ST_EXT: begin
               if (type_changed) begin
                  acq_state <= acq_pkg::ST_READY;
               end else if (fire) begin
                  acq_state <= acq_pkg::ST_POST;
               end
            end
            acq_pkg::ST_POST: begin
               if (len_last) begin
                  len_cnt     <= '0;
                  event_count <= event_count + 1'b1; // event complete
                  acq_state   <= acq_pkg::ST_DONE;
               end else if (strobe) begin
                  len_cnt <= len_cnt + 1'b1;
               end
            end
            acq_pkg::ST_DONE: begin
               if (readout_done) begin
                  acq_state <= acq_pkg::ST_READY;
               end
            end
            default: acq_state <= acq_pkg::ST_READY;
         endcase
      end
   end

   // where and when the trigger happened, held for the reader
   always_ff @(posedge clklvds) begin
      if (fire) begin
         ram_address_triggered <= ram_wr_address;
         event_time            <= time_cnt;
      end
   end

endmodule

`default_nettype wire

// ==== hw/acq_pkg.sv ====
// state codes match the host software numbering; lvds chain types 3 and 30 are not supported
`default_nettype none

package acq_pkg;

   localparam int ADDR_W = 10; // ram write address bits
   localparam int LEN_W  = 16; // pre and post sample count width
   localparam int TIME_W = 32; // event time and event count width

   // acquisition state codes, values read back by the host
   typedef enum logic [7:0] {
      ST_READY     = 8'd0,   // idle, ram not written
      ST_EDGE_ARM  = 8'd1,   // waiting for the first half of a crossing
      ST_EDGE_FIRE = 8'd2,   // waiting for the second half
      ST_AUTO      = 8'd6,   // unconditional trigger
      ST_EXT       = 8'd7,   // back panel trigger with tot check
      ST_PRE       = 8'd200, // filling the pre-trigger window
      ST_POST      = 8'd250, // triggered, filling the post window
      ST_DONE      = 8'd251  // holding until the reader is finished
   } acq_state_t;

   // trigger type codes as written by the host
   localparam logic [7:0] TRIG_NONE    = 8'd0; // conditional triggering off
   localparam logic [7:0] TRIG_RISING  = 8'd1; // threshold, rising edge
   localparam logic [7:0] TRIG_FALLING = 8'd2; // threshold, falling edge
   localparam logic [7:0] TRIG_AUTO    = 8'd4; // force capture
   localparam logic [7:0] TRIG_EXT     = 8'd5; // back panel sma input

endpackage

`default_nettype wire

// ==== hw/acq_trigger_top.sv ====
// all configuration inputs must already be in the clklvds domain; only ext_trig_in is synchronized
`default_nettype none

module acq_trigger_top #(
   parameter int ADDR_W = acq_pkg::ADDR_W,
   parameter int TOT_W  = 8
) (
   input  logic                       clklvds,
   input  logic                       rst_n,
   input  logic                       trigger_live,
   input  logic [7:0]                 trigger_type,
   input  logic [acq_pkg::LEN_W-1:0]  pre_length,
   input  logic [acq_pkg::LEN_W-1:0]  post_length,
   input  sample_pkg::sample_t        lower_thresh,
   input  sample_pkg::sample_t        upper_thresh,
   input  logic                       dual_channel,
   input  logic                       trigger_chan,
   input  logic [4:0]                 downsample,
   input  logic [7:0]                 downsample_merge,
   input  logic [TOT_W-1:0]           ext_tot,
   input  sample_pkg::sample_bus_t    samples,
   input  logic                       ext_trig_in,
   input  logic                       readout_done,
   output logic                       ram_wr,
   output logic [ADDR_W-1:0]          ram_wr_address,
   output logic [ADDR_W-1:0]          ram_address_triggered,
   output acq_pkg::acq_state_t        acq_state,
   output logic                       trig_out,
   output logic [acq_pkg::TIME_W-1:0] event_count,
   output logic [acq_pkg::TIME_W-1:0] event_time
);

   logic recording;  // fsm wants ram writes
   logic strobe;     // one merged sample
   logic rising;     // edge polarity of the active type
   logic ext_enable; // fsm sits in the ext state
   logic arm_hit;
   logic fire_hit;
   logic ext_fire;

   sample_pacer #(
      .ADDR_W (ADDR_W)
   ) i_pacer (
      .clklvds          (clklvds),
      .rst_n            (rst_n),
      .recording        (recording),
      .downsample       (downsample),
      .downsample_merge (downsample_merge),
      .strobe           (strobe),
      .ram_wr           (ram_wr),
      .ram_wr_address   (ram_wr_address)
   );

   edge_detector i_edge (
      .samples      (samples),
      .lower_thresh (lower_thresh),
      .upper_thresh (upper_thresh),
      .rising       (rising),
      .dual_channel (dual_channel),
      .trigger_chan (trigger_chan),
      .arm_hit      (arm_hit),
      .fire_hit     (fire_hit)
   );

   ext_trig_qualifier #(
      .TOT_W (TOT_W)
   ) i_ext (
      .clklvds     (clklvds),
      .rst_n       (rst_n),
      .ext_trig_in (ext_trig_in),
      .enable      (ext_enable),
      .ext_tot     (ext_tot),
      .ext_fire    (ext_fire)
   );

   acq_fsm #(
      .ADDR_W (ADDR_W)
   ) i_fsm (
      .clklvds               (clklvds),
      .rst_n                 (rst_n),
      .trigger_live          (trigger_live),
      .trigger_type          (trigger_type),
      .pre_length            (pre_length),
      .post_length           (post_length),
      .readout_done          (readout_done),
      .strobe                (strobe),
      .ram_wr_address        (ram_wr_address),
      .arm_hit               (arm_hit),
      .fire_hit              (fire_hit),
      .ext_fire              (ext_fire),
      .recording             (recording),
      .rising                (rising),
      .ext_enable            (ext_enable),
      .trig_out              (trig_out),
      .acq_state             (acq_state),
      .ram_address_triggered (ram_address_triggered),
      .event_count           (event_count),
      .event_time            (event_time)
   );

endmodule

`default_nettype wire

// ==== hw/edge_detector.sv ====
// purely combinational; thresholds compare signed and strict, equal values never arm or fire
`default_nettype none

module edge_detector (
   input  sample_pkg::sample_bus_t samples,
   input  sample_pkg::sample_t     lower_thresh,
   input  sample_pkg::sample_t     upper_thresh,
   input  logic                    rising,       // 0 swaps arm and fire tests
   input  logic                    dual_channel, // mask lanes by channel
   input  logic                    trigger_chan, // channel used in dual mode
   output logic                    arm_hit,
   output logic                    fire_hit
);

   logic [sample_pkg::LANES-1:0] lane_en;    // lane takes part in the test
   logic [sample_pkg::LANES-1:0] lane_below; // some sample under lower_thresh
   logic [sample_pkg::LANES-1:0] lane_above; // some sample over upper_thresh

   always_comb begin
      sample_pkg::sample_t s;
      lane_en    = '0;
      lane_below = '0;
      lane_above = '0;
      for (int l = 0; l < sample_pkg::LANES; l++) begin
         // even lanes are channel 0, odd lanes channel 1
         lane_en[l] = !dual_channel || (l[0] == trigger_chan);
         for (int k = 0; k < sample_pkg::LANE_SAMPLES; k++) begin
            s = samples[l][k];
            if (s < lower_thresh) begin
               lane_below[l] = 1'b1;
            end
            if (s > upper_thresh) begin
               lane_above[l] = 1'b1;
            end
         end
      end
   end

   // rising edge arms below and fires above, falling is the mirror
   assign arm_hit  = rising ? |(lane_en & lane_below) : |(lane_en & lane_above);
   assign fire_hit = rising ? |(lane_en & lane_above) : |(lane_en & lane_below);

endmodule

`default_nettype wire

// ==== hw/ext_trig_qualifier.sv ====
// ext_trig_in is asynchronous; an input already high when enable rises waits for the next edge
`default_nettype none

module ext_trig_qualifier #(
   parameter int TOT_W = 8
) (
   input  logic             clklvds,
   input  logic             rst_n,
   input  logic             ext_trig_in, // back panel sma, async
   input  logic             enable,      // fsm waits in the ext state
   input  logic [TOT_W-1:0] ext_tot,     // high clocks needed after the edge
   output logic             ext_fire
);

   logic             sync_meta; // first synchronizer stage
   logic             sync_q;    // synchronized input
   logic             sync_last; // previous synchronized value
   logic             latched;   // rising edge seen while enabled
   logic             rise;
   logic             seen;
   logic [TOT_W-1:0] tot_cnt;   // consecutive high clocks since the edge

   assign rise     = sync_q && !sync_last;
   assign seen     = latched || rise; // edge counts in its own clock
   assign ext_fire = enable && seen && sync_q && (tot_cnt >= ext_tot);

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         sync_meta <= 1'b0;
         sync_q    <= 1'b0;
         sync_last <= 1'b0;
         latched   <= 1'b0;
         tot_cnt   <= '0;
      end else begin
         sync_meta <= ext_trig_in;
         sync_q    <= sync_meta;
         sync_last <= sync_q;
         if (!enable) begin
            latched <= 1'b0; // forget everything outside the ext state
            tot_cnt <= '0;
         end else begin
            if (rise) begin
               latched <= 1'b1;
            end
            if (seen && sync_q) begin
               if (tot_cnt != '1) begin
                  tot_cnt <= tot_cnt + 1'b1; // saturate, no wrap
               end
            end else begin
               tot_cnt <= '0; // input dropped before tot was met
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/sample_pacer.sv ====
// downsample and merge settings must stay static while recording; merge of 0 merges 256 ticks
`default_nettype none

module sample_pacer #(
   parameter int ADDR_W = 10
) (
   input  logic              clklvds,
   input  logic              rst_n,
   input  logic              recording,        // high while the fsm wants ram writes
   input  logic [4:0]        downsample,       // divide by 2^downsample
   input  logic [7:0]        downsample_merge, // ticks merged per write, 1..255
   output logic              strobe,           // one clock per merged sample
   output logic              ram_wr,
   output logic [ADDR_W-1:0] ram_wr_address
);

   logic [31:0] div_cnt;   // runs 1..2^downsample, checked by one bit
   logic [7:0]  merge_cnt; // divider ticks seen in this merge
   logic        div_tick;

   assign div_tick = div_cnt[downsample]; // reached 2^downsample
   assign ram_wr   = strobe;              // every strobe is a ram write

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt        <= 32'd1;
         merge_cnt      <= 8'd1;
         strobe         <= 1'b0;
         ram_wr_address <= '0;
      end else if (!recording) begin
         div_cnt   <= 32'd1; // restart so the first write is a full period away
         merge_cnt <= 8'd1;
         strobe    <= 1'b0;
      end else if (div_tick) begin
         div_cnt <= 32'd1;
         if (merge_cnt == downsample_merge) begin
            merge_cnt      <= 8'd1;
            strobe         <= 1'b1;
            ram_wr_address <= ram_wr_address + 1'b1; // wraps around the ram
         end else begin
            merge_cnt <= merge_cnt + 8'd1;
            strobe    <= 1'b0;
         end
      end else begin
         div_cnt <= div_cnt + 32'd1;
         strobe  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== hw/sample_pkg.sv ====
// fixed layout of four lanes of ten signed samples; lanes 0/2 are channel 0, lanes 1/3 channel 1
`default_nettype none

package sample_pkg;

   localparam int SAMPLE_W     = 12; // adc resolution
   localparam int LANES        = 4;  // lvds lanes from the adc
   localparam int LANE_SAMPLES = 10; // samples per lane per clock

   typedef logic signed [SAMPLE_W-1:0] sample_t; // one adc sample

   // all 40 samples of one clock, indexed [lane][sample]
   typedef sample_t [LANES-1:0][LANE_SAMPLES-1:0] sample_bus_t;

endpackage

`default_nettype wire

// ==== test/tb_acq_trigger.sv ====
// runs with downsample 1 and merge 3 throughout; checks sample at the rising edge, inputs move 1 unit later
`default_nettype none

module tb_acq_trigger;

   localparam int ADDR_W    = acq_pkg::ADDR_W;
   localparam int TOT_W     = 8;
   localparam int RUN_LIMIT = 2 * (10 + 150 + 100 + 100 + 100 + 60 + 120); // twice the test budgets

   logic                       clklvds;
   logic                       rst_n;
   logic                       trigger_live;
   logic [7:0]                 trigger_type;
   logic [acq_pkg::LEN_W-1:0]  pre_length;
   logic [acq_pkg::LEN_W-1:0]  post_length;
   sample_pkg::sample_t        lower_thresh;
   sample_pkg::sample_t        upper_thresh;
   logic                       dual_channel;
   logic                       trigger_chan;
   logic [4:0]                 downsample;
   logic [7:0]                 downsample_merge;
   logic [TOT_W-1:0]           ext_tot;
   sample_pkg::sample_bus_t    samples;
   logic                       ext_trig_in;
   logic                       readout_done;
   logic                       ram_wr;
   logic [ADDR_W-1:0]          ram_wr_address;
   logic [ADDR_W-1:0]          ram_address_triggered;
   acq_pkg::acq_state_t        acq_state;
   logic                       trig_out;
   logic [acq_pkg::TIME_W-1:0] event_count;
   logic [acq_pkg::TIME_W-1:0] event_time;

   acq_pkg::acq_state_t        prev_state;   // reference model, values seen one edge back
   logic [7:0]                 prev_type;
   logic                       prev_live;
   logic                       prev_readout;
   logic [ADDR_W-1:0]          prev_addr;
   logic [acq_pkg::TIME_W-1:0] prev_tcount;
   logic [ADDR_W-1:0]          exp_addr;     // expected address, one step per write
   logic [7:0]                 active_type;  // type taken when leaving ready
   logic [acq_pkg::TIME_W-1:0] ev_ref;       // expected event count
   logic [acq_pkg::TIME_W-1:0] tcount;       // mirrors the free running time
   logic                       have_pulse;   // a write already seen in this run
   logic                       reset_seen;
   int                         gap;          // clocks since the last write
   int                         period;
   int                         pre_cnt;
   int                         post_cnt;
   int                         errors;
   int                         err_mark;     // errors when the current test began
   int                         tests_run;
   int                         tests_failed;
   int                         cycles;
   int                         spike_lane;   // -1 means background only
   sample_pkg::sample_t        spike_val;
   logic [31:0]                lcg_state;
   logic [ADDR_W-1:0]          fire_addr;

   tb_clk_gen i_clk_gen (
      .clklvds (clklvds),
      .rst_n   (rst_n)
   );

   acq_trigger_top #(
      .ADDR_W (ADDR_W),
      .TOT_W  (TOT_W)
   ) i_dut (
      .clklvds               (clklvds),
      .rst_n                 (rst_n),
      .trigger_live          (trigger_live),
      .trigger_type          (trigger_type),
      .pre_length            (pre_length),
      .post_length           (post_length),
      .lower_thresh          (lower_thresh),
      .upper_thresh          (upper_thresh),
      .dual_channel          (dual_channel),
      .trigger_chan          (trigger_chan),
      .downsample            (downsample),
      .downsample_merge      (downsample_merge),
      .ext_tot               (ext_tot),
      .samples               (samples),
      .ext_trig_in           (ext_trig_in),
      .readout_done          (readout_done),
      .ram_wr                (ram_wr),
      .ram_wr_address        (ram_wr_address),
      .ram_address_triggered (ram_address_triggered),
      .acq_state             (acq_state),
      .trig_out              (trig_out),
      .event_count           (event_count),
      .event_time            (event_time)
   );

   task automatic report_mismatch(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   // states that wait for a trigger condition
   function automatic logic in_trigger_wait(input acq_pkg::acq_state_t st);
      return st == acq_pkg::ST_EDGE_ARM || st == acq_pkg::ST_EDGE_FIRE ||
             st == acq_pkg::ST_AUTO || st == acq_pkg::ST_EXT;
   endfunction

   function sample_pkg::sample_t lcg_sample();
      int v;
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      v = lcg_state[30:16];
      v = v % 801 - 400; // stays well inside the thresholds
      return v[sample_pkg::SAMPLE_W-1:0];
   endfunction

   task fill_samples();
      for (int l = 0; l < sample_pkg::LANES; l++) begin
         for (int k = 0; k < sample_pkg::LANE_SAMPLES; k++) begin
            samples[l][k] = lcg_sample();
         end
      end
      if (spike_lane >= 0) begin
         samples[spike_lane][3] = spike_val; // one crossing sample in the chosen lane
      end
   endtask

   task step();
      @(posedge clklvds);
      #1;
      fill_samples();
   endtask

   task automatic wait_state(input acq_pkg::acq_state_t st, input int max_cycles);
      int n;
      n = 0;
      while (acq_state != st && n < max_cycles) begin
         step();
         n++;
      end
      if (acq_state != st) begin
         errors++;
         $display("timed out at %0t waiting for acq_state %0d", $time, st);
      end
   endtask

   task automatic start_acq(input logic [7:0] kind);
      trigger_type = kind;
      trigger_live = 1'b1;
      wait_state(acq_pkg::ST_PRE, 4);
      trigger_live = 1'b0; // one acquisition only
   endtask

   task read_out();
      wait_state(acq_pkg::ST_DONE, 200);
      repeat (4) step();
      assert (acq_state == acq_pkg::ST_DONE) else report_mismatch("done left without readout");
      readout_done = 1'b1;
      step();
      assert (acq_state == acq_pkg::ST_READY) else report_mismatch("done held after readout");
      readout_done = 1'b0;
   endtask

   task automatic edge_run(input logic [7:0] kind, input int lane, input int arm_val,
                           input int fire_val);
      start_acq(kind);
      wait_state(acq_pkg::ST_EDGE_ARM, 200);
      spike_lane = lane;
      spike_val  = arm_val[sample_pkg::SAMPLE_W-1:0];
      fill_samples();
      wait_state(acq_pkg::ST_EDGE_FIRE, 4);
      spike_val = fire_val[sample_pkg::SAMPLE_W-1:0];
      fill_samples();
      fire_addr = ram_wr_address; // address in the clock that fires
      wait_state(acq_pkg::ST_POST, 4);
      assert (ram_address_triggered == fire_addr)
         else report_mismatch($sformatf("triggered address %0d, expected %0d",
                                        ram_address_triggered, fire_addr));
      spike_lane = -1;
      read_out();
   endtask

   task report_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // reference model and checks, evaluated on values before each edge
   always @(posedge clklvds) begin
      if (!rst_n) begin
         if (reset_seen) begin
            assert (!ram_wr && !trig_out && acq_state == acq_pkg::ST_READY && event_count == '0)
               else report_mismatch("outputs not idle during reset");
         end
         reset_seen  = 1'b1;
         prev_state  = acq_pkg::ST_READY;
         prev_type   = '0;
         prev_live   = 1'b0;
         prev_readout = 1'b0;
         exp_addr    = '0;
         active_type = '0;
         ev_ref      = '0;
         tcount      = '0;
         have_pulse  = 1'b0;
         gap         = 0;
         pre_cnt     = 0;
         post_cnt    = 0;
      end else begin
         period = (1 << downsample) * downsample_merge;
         assert (ram_wr_address == (ram_wr ? exp_addr + 1'b1 : exp_addr))
            else report_mismatch($sformatf("ram_wr_address %0d after %0d, ram_wr %0b",
                                           ram_wr_address, exp_addr, ram_wr));
         if (ram_wr) begin
            exp_addr = exp_addr + 1'b1; // wraps with the address width
         end
         if (acq_state == acq_pkg::ST_READY || acq_state == acq_pkg::ST_DONE) begin
            have_pulse = 1'b0; // pacer restarts with recording
            gap        = 0;
         end else begin
            gap = gap + 1;
            if (ram_wr) begin
               if (have_pulse) begin
                  assert (gap == period)
                     else report_mismatch($sformatf("write gap %0d, expected %0d", gap, period));
               end
               have_pulse = 1'b1;
               gap        = 0;
            end
         end
         if (prev_state == acq_pkg::ST_READY && prev_live && prev_type != acq_pkg::TRIG_NONE) begin
            assert (acq_state == acq_pkg::ST_PRE) else report_mismatch("ready did not start pre");
            active_type = prev_type;
         end
         if ((prev_state == acq_pkg::ST_PRE || in_trigger_wait(prev_state)) &&
             prev_type != active_type) begin
            assert (acq_state == acq_pkg::ST_READY) else report_mismatch("type change kept running");
         end
         if (prev_state == acq_pkg::ST_PRE && in_trigger_wait(acq_state)) begin
            assert (pre_cnt == pre_length)
               else report_mismatch($sformatf("%0d pre writes, expected %0d", pre_cnt, pre_length));
         end
         if (in_trigger_wait(prev_state) && acq_state == acq_pkg::ST_POST) begin
            assert (ram_address_triggered == prev_addr && event_time == prev_tcount)
               else report_mismatch("trigger address or time not captured at fire");
         end
         if (prev_state == acq_pkg::ST_POST && acq_state == acq_pkg::ST_DONE) begin
            assert (post_cnt == post_length)
               else report_mismatch($sformatf("%0d post writes, expected %0d", post_cnt, post_length));
            ev_ref = ev_ref + 1'b1; // one event per completed post window
         end
         if (prev_state == acq_pkg::ST_DONE) begin
            assert (acq_state == (prev_readout ? acq_pkg::ST_READY : acq_pkg::ST_DONE))
               else report_mismatch("done did not follow readout_done");
         end
         assert (event_count == ev_ref)
            else report_mismatch($sformatf("event_count %0d, expected %0d", event_count, ev_ref));
         assert (!(acq_state == acq_pkg::ST_DONE && ram_wr)) else report_mismatch("write in done");
         if (acq_state == acq_pkg::ST_READY) begin
            pre_cnt  = 0;
            post_cnt = 0;
         end
         if (acq_state == acq_pkg::ST_PRE && ram_wr) begin
            pre_cnt++;
         end
         if (trig_out && ram_wr) begin
            post_cnt++;
         end
         prev_state   = acq_state;
         prev_type    = trigger_type;
         prev_live    = trigger_live;
         prev_readout = readout_done;
         prev_addr    = ram_wr_address;
         prev_tcount  = tcount;
         tcount       = tcount + 1'b1;
      end
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < RUN_LIMIT) begin
         @(posedge clklvds);
         cycles++;
      end
      $display("run stopped after %0d cycles, a test never finished", cycles);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      trigger_live     = 1'b0;
      trigger_type     = acq_pkg::TRIG_NONE;
      pre_length       = 16'd10;
      post_length      = 16'd6;
      lower_thresh     = -12'sd500;
      upper_thresh     = 12'sd500;
      dual_channel     = 1'b0;
      trigger_chan     = 1'b0;
      downsample       = 5'd1;  // period of 2 x 3 = 6 clocks
      downsample_merge = 8'd3;
      ext_tot          = 8'd4;
      ext_trig_in      = 1'b0;
      readout_done     = 1'b0;
      errors           = 0;
      err_mark         = 0;
      tests_run        = 0;
      tests_failed     = 0;
      reset_seen       = 1'b0;
      spike_lane       = -1;
      spike_val        = '0;
      lcg_state        = 32'd98;
      fill_samples();
      @(posedge rst_n);
      step();

      start_acq(acq_pkg::TRIG_AUTO); // long pre window for many write gaps
      read_out();
      report_test("pacing");

      pre_length  = 16'd4;
      post_length = 16'd5;
      start_acq(acq_pkg::TRIG_AUTO);
      read_out();
      report_test("auto trigger and readout");

      edge_run(acq_pkg::TRIG_RISING, 0, -1000, 1000);
      report_test("rising edge");

      dual_channel = 1'b1;
      trigger_chan = 1'b1;                            // lane 3 belongs to channel 1
      edge_run(acq_pkg::TRIG_FALLING, 3, 1000, -1000);
      report_test("falling edge dual channel");

      trigger_chan = 1'b0;
      start_acq(acq_pkg::TRIG_RISING);
      wait_state(acq_pkg::ST_EDGE_ARM, 200);
      spike_lane = 1; // channel 1 lane, masked
      spike_val  = -12'sd1000;
      repeat (3) step();
      spike_val = 12'sd1000;
      repeat (3) step();
      assert (acq_state == acq_pkg::ST_EDGE_ARM) else report_mismatch("masked lane moved the fsm");
      spike_lane   = -1;
      trigger_type = acq_pkg::TRIG_FALLING; // abort
      step();
      assert (acq_state == acq_pkg::ST_READY) else report_mismatch("abort did not reach ready");
      report_test("masked lane and abort");

      dual_channel = 1'b0;
      start_acq(acq_pkg::TRIG_EXT);
      wait_state(acq_pkg::ST_EXT, 200);
      ext_trig_in = 1'b1;
      repeat (4) step(); // high for exactly ext_tot clocks
      ext_trig_in = 1'b0;
      repeat (6) step();
      assert (acq_state == acq_pkg::ST_EXT) else report_mismatch("short ext pulse fired");
      ext_trig_in = 1'b1;
      for (int n = 1; n <= 10; n++) begin
         step();
         if (n == 8) begin
            ext_trig_in = 1'b0;
         end
         if (n < ext_tot + 3) begin
            assert (acq_state == acq_pkg::ST_EXT)
               else report_mismatch($sformatf("left ext %0d clocks after the edge", n));
         end else if (n == ext_tot + 3) begin
            assert (acq_state == acq_pkg::ST_POST)
               else report_mismatch($sformatf("not in post %0d clocks after the edge", n));
         end
      end
      read_out();
      report_test("external trigger");

      repeat (2) step();
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// free running clock of period 10; rst_n is released 1 unit after the tenth rising edge
`default_nettype none

module tb_clk_gen (
   output logic clklvds,
   output logic rst_n
);

   initial begin
      clklvds = 1'b0;
      forever #5 clklvds = ~clklvds; // 10 unit period
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clklvds);
      #1 rst_n = 1'b1; // same offset as the other dut inputs
   end

endmodule

`default_nettype wire
